//--- files.f
+incdir+include
verilog/shfifo_pkg.sv
verilog/shfifo_freelist.sv
verilog/shfifo_push_ctrl.sv
verilog/shfifo_linked_list.sv
verilog/shfifo_pop_ctrl.sv
verilog/shfifo_data_ram.sv
verilog/shfifo_apb_regs.sv
verilog/shfifo_top.sv
verif/shfifo_tb.sv

//--- Makefile
# Verilator build and run for the shared-storage multi-FIFO testbench

VERILATOR   ?= verilator
TOP         ?= shfifo_tb
FILELIST    ?= files.f
BUILD_DIR   ?= obj_dir
PASS_STRING ?= TESTS PASSED
VFLAGS      ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# Fails unless the simulation output holds the pass string
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_STRING)"

clean:
	rm -rf $(BUILD_DIR)

//--- verif/shfifo_tb.sv
// Shared-storage multi-FIFO testbench
// Directed tests over the push, pop and APB ports with per-FIFO scoreboards

`timescale 1ns/1ps
`include "shfifo_config.svh"

module shfifo_tb;
  import shfifo_pkg::*;

  // About 70 pushes and pops plus 25 APB accesses, each well under 20 cycles
  localparam int TIMEOUT_CYCLES = 4000;

  logic                                 clk = 1'b0;
  logic                                 rst = 1'b1;
  logic                                 push_valid = 1'b0;
  push_req_t                            push_req = '0;
  logic                                 push_ready;
  logic     [`SHFIFO_NUM_FIFOS-1:0]     pop_valid;
  logic     [`SHFIFO_NUM_FIFOS-1:0]     pop_ready = '0;
  data_t    [`SHFIFO_NUM_FIFOS-1:0]     pop_data;
  apb_req_t                             apb_req = '0;
  apb_rsp_t                             apb_rsp;

  integer   seed = 91;
  int       cycles = 0;
  int       errors = 0;
  int       checks = 0;
  int       pops = 0;
  logic     watch_fifo1 = 1'b0;
  // Expected pop data, one queue per FIFO
  data_t    exp_q0 [$];
  data_t    exp_q1 [$];

  shfifo_top i_dut (
    .clk, .rst, .push_valid, .push_req, .push_ready,
    .pop_valid, .pop_ready, .pop_data, .apb_req, .apb_rsp
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // FIFO 1 must stay silent while its pop enable is cleared
  always @(negedge clk) begin
    if (watch_fifo1) begin
      assert (!pop_valid[1]) else begin
        errors++;
        $display("FIFO 1 presented data at %0t ns while its pop enable was cleared", $time);
      end
    end
  end

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAILED at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
    end
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    @(posedge clk);
    apb_req.psel <= 1'b1;
    apb_req.penable <= 1'b0;
    apb_req.pwrite <= 1'b1;
    apb_req.paddr <= addr;
    apb_req.pwdata <= data;
    @(posedge clk);
    apb_req.penable <= 1'b1;
    @(negedge clk);
    compare_value("pready", 32'(apb_rsp.pready), 1);
    @(posedge clk);
    apb_req <= '0;
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                          output logic err);
    @(posedge clk);
    apb_req.psel <= 1'b1;
    apb_req.penable <= 1'b0;
    apb_req.pwrite <= 1'b0;
    apb_req.paddr <= addr;
    @(posedge clk);
    apb_req.penable <= 1'b1;
    // Read data is combinational during the access phase
    @(negedge clk);
    compare_value("pready", 32'(apb_rsp.pready), 1);
    data = apb_rsp.prdata;
    err = apb_rsp.pslverr;
    @(posedge clk);
    apb_req <= '0;
  endtask

  task automatic read_expect(input logic [7:0] addr, input string name,
                             input logic [31:0] exp);
    logic [31:0] data;
    logic        err;
    apb_read(addr, data, err);
    compare_value({name, " pslverr"}, 32'(err), 0);
    compare_value(name, data, exp);
  endtask

  // Holds the request until the handshake, then records it as expected
  task automatic push_one(input fifo_id_t id, input data_t data);
    @(posedge clk);
    push_valid <= 1'b1;
    push_req.fifo_id <= id;
    push_req.data <= data;
    @(negedge clk);
    while (!push_ready) @(negedge clk);
    @(posedge clk);
    push_valid <= 1'b0;
    if (id == 1'b0) exp_q0.push_back(data);
    else exp_q1.push_back(data);
  endtask

  // Looks at push_ready for one FIFO without offering a push
  task automatic probe_ready(input fifo_id_t id, input logic exp);
    @(posedge clk);
    push_valid <= 1'b0;
    push_req.fifo_id <= id;
    @(negedge clk);
    compare_value($sformatf("push_ready for FIFO %0d", id), 32'(push_ready), 32'(exp));
  endtask

  task automatic pop_one(input fifo_id_t id);
    data_t exp;
    logic  have;
    @(negedge clk);
    while (!pop_valid[id]) @(negedge clk);
    have = (id == 1'b0) ? (exp_q0.size() != 0) : (exp_q1.size() != 0);
    assert (have) else begin
      errors++;
      $display("FIFO %0d popped data at %0t ns that was never pushed", id, $time);
    end
    if (have) begin
      exp = (id == 1'b0) ? exp_q0.pop_front() : exp_q1.pop_front();
      compare_value($sformatf("pop_data[%0d]", id), 32'(pop_data[id]), 32'(exp));
    end
    @(posedge clk);
    pop_ready[id] <= 1'b1;
    @(posedge clk);
    pop_ready[id] <= 1'b0;
    pops++;
  endtask

  task automatic drain_all();
    while (exp_q0.size() != 0) pop_one(1'b0);
    while (exp_q1.size() != 0) pop_one(1'b1);
  endtask

  task automatic test_defaults();
    logic [31:0] data;
    logic        err;
    read_expect(8'h00, "POP_EN", 32'h3);
    read_expect(8'h04, "LIMIT0", `SHFIFO_DEPTH);
    read_expect(8'h08, "LIMIT1", `SHFIFO_DEPTH);
    read_expect(8'h10, "COUNT0", 0);
    read_expect(8'h14, "COUNT1", 0);
    read_expect(8'h18, "FREE_COUNT", `SHFIFO_DEPTH);
    read_expect(8'h1C, "DEALLOC_TOTAL", 0);
    apb_read(8'h40, data, err);
    compare_value("pslverr at 0x40", 32'(err), 1);
  endtask

  task automatic test_single_order();
    repeat (5) push_one(1'b0, data_t'($random(seed)));
    repeat (5) pop_one(1'b0);
    read_expect(8'h10, "COUNT0", 0);
  endtask

  task automatic test_interleaved();
    // Two rounds keep the load below the shared storage
    repeat (2) begin
      repeat (6) push_one(fifo_id_t'($random(seed) & 1), data_t'($random(seed)));
      drain_all();
    end
  endtask

  task automatic test_full_storage();
    apb_write(8'h00, 32'h0);
    for (int i = 0; i < `SHFIFO_DEPTH; i++) push_one(fifo_id_t'(i % 2), data_t'($random(seed)));
    repeat (3) begin
      probe_ready(1'b0, 1'b0);
      probe_ready(1'b1, 1'b0);
    end
    read_expect(8'h18, "FREE_COUNT", 0);
    apb_write(8'h00, 32'h3);
    drain_all();
    // Last entries need the recycle delay before they count as free
    repeat (`SHFIFO_DEALLOC_DELAY + 3) @(posedge clk);
    read_expect(8'h18, "FREE_COUNT", `SHFIFO_DEPTH);
  endtask

  task automatic test_limit();
    apb_write(8'h00, 32'h0);
    apb_write(8'h04, 32'd3);
    repeat (3) push_one(1'b0, data_t'($random(seed)));
    read_expect(8'h10, "COUNT0", 3);
    probe_ready(1'b0, 1'b0);
    probe_ready(1'b1, 1'b1);
    push_one(1'b1, data_t'($random(seed)));
    apb_write(8'h04, `SHFIFO_DEPTH);
    apb_write(8'h00, 32'h3);
    drain_all();
  endtask

  task automatic test_pop_enable();
    apb_write(8'h00, 32'h1);
    watch_fifo1 = 1'b1;
    repeat (3) push_one(1'b0, data_t'($random(seed)));
    repeat (2) push_one(1'b1, data_t'($random(seed)));
    repeat (3) pop_one(1'b0);
    repeat (8) @(posedge clk);
    watch_fifo1 = 1'b0;
    read_expect(8'h14, "COUNT1", 2);
    read_expect(8'h1C, "DEALLOC_TOTAL", pops);
    // Re-enabled FIFO 1 drains and its entries join the total
    apb_write(8'h00, 32'h3);
    drain_all();
    repeat (8) @(posedge clk);
    read_expect(8'h1C, "DEALLOC_TOTAL", pops);
  endtask

  initial begin
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    test_defaults();
    test_single_order();
    test_interleaved();
    test_full_storage();
    test_limit();
    test_pop_enable();
    repeat (4) @(posedge clk);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- verilog/shfifo_top.sv
// Shared-storage multi-FIFO top level
// Push and pop datapath around one shared RAM, steered by the APB registers

`timescale 1ns/1ps
`include "shfifo_config.svh"

module shfifo_top (
  input  logic                                       clk,
  input  logic                                       rst,
  input  logic                                       push_valid,
  input  shfifo_pkg::push_req_t                      push_req,
  output logic                                       push_ready,
  output logic [`SHFIFO_NUM_FIFOS-1:0]               pop_valid,
  input  logic [`SHFIFO_NUM_FIFOS-1:0]               pop_ready,
  output shfifo_pkg::data_t [`SHFIFO_NUM_FIFOS-1:0]  pop_data,
  input  shfifo_pkg::apb_req_t                       apb_req,
  output shfifo_pkg::apb_rsp_t                       apb_rsp
);
  import shfifo_pkg::*;

  // Free list
  logic                           alloc_sendable;
  addr_t                          alloc_entry;
  logic                           alloc_take;
  dealloc_t                       dealloc;
  logic                           dealloc_count;
  count_t                         free_count;
  // Register controls and list state
  count_t [`SHFIFO_NUM_FIFOS-1:0] fifo_count;
  count_t [`SHFIFO_NUM_FIFOS-1:0] fifo_limit;
  logic   [`SHFIFO_NUM_FIFOS-1:0] pop_en;
  addr_t  [`SHFIFO_NUM_FIFOS-1:0] head;
  logic                           tail_upd_valid;
  tail_upd_t                      tail_upd;
  logic                           head_adv;
  fifo_id_t                       head_adv_id;
  // RAM ports
  logic                           ram_wr_valid;
  ram_wr_t                        ram_wr;
  logic                           rd_en;
  addr_t                          rd_addr;
  data_t                          rd_data;

  shfifo_freelist i_freelist (
    .clk, .rst, .alloc_sendable, .alloc_entry, .alloc_take,
    .dealloc, .dealloc_count, .free_count
  );

  shfifo_push_ctrl i_push_ctrl (
    .push_valid, .push_req, .push_ready, .alloc_sendable, .alloc_entry,
    .alloc_take, .fifo_count, .fifo_limit, .ram_wr_valid, .ram_wr,
    .tail_upd_valid, .tail_upd
  );

  shfifo_linked_list i_linked_list (
    .clk, .rst, .tail_upd_valid, .tail_upd, .head_adv, .head_adv_id,
    .head, .fifo_count
  );

  shfifo_pop_ctrl i_pop_ctrl (
    .clk, .rst, .fifo_count, .head, .pop_en, .rd_en, .rd_addr, .rd_data,
    .head_adv, .head_adv_id, .dealloc, .pop_valid, .pop_ready, .pop_data
  );

  shfifo_data_ram i_data_ram (
    .clk, .wr_valid(ram_wr_valid), .wr(ram_wr), .rd_en, .rd_addr, .rd_data
  );

  shfifo_apb_regs i_apb_regs (
    .clk, .rst, .apb_req, .apb_rsp, .fifo_count, .free_count,
    .dealloc_count, .fifo_limit, .pop_en
  );

endmodule

//--- verilog/shfifo_apb_regs.sv
// APB register block
// Holds per-FIFO limits and the pop-enable mask, reports occupancy,
// free entries and the running deallocation total

`timescale 1ns/1ps
`include "shfifo_config.svh"

module shfifo_apb_regs (
  input  logic                                        clk,
  input  logic                                        rst,
  input  shfifo_pkg::apb_req_t                        apb_req,
  output shfifo_pkg::apb_rsp_t                        apb_rsp,
  input  shfifo_pkg::count_t [`SHFIFO_NUM_FIFOS-1:0]  fifo_count,
  input  shfifo_pkg::count_t                          free_count,
  input  logic                                        dealloc_count,
  output shfifo_pkg::count_t [`SHFIFO_NUM_FIFOS-1:0]  fifo_limit,
  output logic [`SHFIFO_NUM_FIFOS-1:0]                pop_en
);
  import shfifo_pkg::*;

  logic [`SHFIFO_NUM_FIFOS-1:0] pop_en_q;
  count_t [`SHFIFO_NUM_FIFOS-1:0] limit_q;
  logic [31:0]                  dealloc_total_q;
  logic [31:0]                  rdata;
  logic                         mapped;
  logic                         access;
  logic                         wr_en;

  assign access = apb_req.psel && apb_req.penable;
  assign wr_en = access && apb_req.pwrite;

  assign pop_en = pop_en_q;
  assign fifo_limit = limit_q;

  // Read mux and address decode
  always_comb begin
    rdata = '0;
    mapped = 1'b1;
    case (apb_req.paddr)
      8'h00: rdata = 32'(pop_en_q);
      8'h04: rdata = 32'(limit_q[0]);
      8'h08: rdata = 32'(limit_q[1]);
      8'h10: rdata = 32'(fifo_count[0]);
      8'h14: rdata = 32'(fifo_count[1]);
      8'h18: rdata = 32'(free_count);
      8'h1C: rdata = dealloc_total_q;
      default: mapped = 1'b0;
    endcase
  end

  // Zero wait states
  assign apb_rsp.pready = 1'b1;
  assign apb_rsp.prdata = rdata;
  assign apb_rsp.pslverr = access && !mapped;

  always_ff @(posedge clk) begin
    if (rst) begin
      pop_en_q <= '1;
      for (int i = 0; i < `SHFIFO_NUM_FIFOS; i++) limit_q[i] <= count_t'(`SHFIFO_DEPTH);
      dealloc_total_q <= '0;
    end else begin
      if (wr_en) begin
        // Writes to status registers are dropped
        case (apb_req.paddr)
          8'h00: pop_en_q <= apb_req.pwdata[`SHFIFO_NUM_FIFOS-1:0];
          8'h04: limit_q[0] <= count_t'(apb_req.pwdata);
          8'h08: limit_q[1] <= count_t'(apb_req.pwdata);
          default: ;
        endcase
      end
      dealloc_total_q <= dealloc_total_q + 32'(dealloc_count);
    end
  end

endmodule

//--- verilog/shfifo_data_ram.sv
// Shared data RAM
// One write port and one read port, read data registered

`timescale 1ns/1ps
`include "shfifo_config.svh"

module shfifo_data_ram (
  input  logic                clk,
  input  logic                wr_valid,
  input  shfifo_pkg::ram_wr_t wr,
  input  logic                rd_en,
  input  shfifo_pkg::addr_t   rd_addr,
  output shfifo_pkg::data_t   rd_data
);
  import shfifo_pkg::*;

  data_t mem [`SHFIFO_DEPTH];

  always_ff @(posedge clk) begin
    if (wr_valid) mem[wr.addr] <= wr.data;
  end

  // Data valid the cycle after rd_en
  always_ff @(posedge clk) begin
    if (rd_en) rd_data <= mem[rd_addr];
  end

endmodule

//--- verilog/shfifo_pop_ctrl.sv
// Pop controller
// Round-robin head reads into per-FIFO output stages, with head advance
// and entry deallocation issued alongside each read

`timescale 1ns/1ps
`include "shfifo_config.svh"

module shfifo_pop_ctrl (
  input  logic                                        clk,
  input  logic                                        rst,
  input  shfifo_pkg::count_t [`SHFIFO_NUM_FIFOS-1:0]  fifo_count,
  input  shfifo_pkg::addr_t [`SHFIFO_NUM_FIFOS-1:0]   head,
  input  logic [`SHFIFO_NUM_FIFOS-1:0]                pop_en,
  output logic                                        rd_en,
  output shfifo_pkg::addr_t                           rd_addr,
  input  shfifo_pkg::data_t                           rd_data,
  output logic                                        head_adv,
  output shfifo_pkg::fifo_id_t                        head_adv_id,
  output shfifo_pkg::dealloc_t                        dealloc,
  output logic [`SHFIFO_NUM_FIFOS-1:0]                pop_valid,
  input  logic [`SHFIFO_NUM_FIFOS-1:0]                pop_ready,
  output shfifo_pkg::data_t [`SHFIFO_NUM_FIFOS-1:0]   pop_data
);
  import shfifo_pkg::*;

  pop_state_e                     state_q;
  fifo_id_t                       pend_id_q;
  fifo_id_t                       rr_q;
  fifo_id_t                       pick;
  logic   [`SHFIFO_NUM_FIFOS-1:0] eligible;
  logic   [`SHFIFO_NUM_FIFOS-1:0] stage_valid_q;
  data_t  [`SHFIFO_NUM_FIFOS-1:0] stage_data_q;

  // Needs data, enabled, room in its stage and no read in flight
  always_comb begin
    for (int i = 0; i < `SHFIFO_NUM_FIFOS; i++) begin
      eligible[i] = (fifo_count[i] != '0) && pop_en[i] && !stage_valid_q[i] &&
                    !((state_q == POP_READ) && (pend_id_q == fifo_id_t'(i)));
    end
  end

  // Search starts just after the last winner
  always_comb begin
    int idx;
    pick = rr_q;
    for (int k = `SHFIFO_NUM_FIFOS; k >= 1; k--) begin
      idx = (int'(rr_q) + k) % `SHFIFO_NUM_FIFOS;
      if (eligible[idx]) pick = fifo_id_t'(idx);
    end
  end

  assign rd_en = |eligible;
  assign rd_addr = head[pick];
  assign head_adv = rd_en;
  assign head_adv_id = pick;
  assign dealloc.valid = rd_en;
  assign dealloc.addr = head[pick];

  assign pop_valid = stage_valid_q;
  assign pop_data = stage_data_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= POP_IDLE;
      pend_id_q <= '0;
      rr_q <= '0;
      stage_valid_q <= '0;
    end else begin
      state_q <= rd_en ? POP_READ : POP_IDLE;
      if (rd_en) begin
        pend_id_q <= pick;
        rr_q <= pick;
      end
      stage_valid_q <= stage_valid_q & ~pop_ready;
      if (state_q == POP_READ) stage_valid_q[pend_id_q] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == POP_READ) stage_data_q[pend_id_q] <= rd_data;
  end

  // One entry per stage, so returning RAM data always lands in an empty stage
  stage_free_on_return_a: assert property (@(posedge clk) disable iff (rst)
    (state_q == POP_READ) |-> !stage_valid_q[pend_id_q]);

endmodule

//--- verilog/shfifo_linked_list.sv
// Linked-list controller
// Per-FIFO head, tail and count over a shared next-pointer table

`timescale 1ns/1ps
`include "shfifo_config.svh"

module shfifo_linked_list (
  input  logic                                        clk,
  input  logic                                        rst,
  input  logic                                        tail_upd_valid,
  input  shfifo_pkg::tail_upd_t                       tail_upd,
  input  logic                                        head_adv,
  input  shfifo_pkg::fifo_id_t                        head_adv_id,
  output shfifo_pkg::addr_t [`SHFIFO_NUM_FIFOS-1:0]   head,
  output shfifo_pkg::count_t [`SHFIFO_NUM_FIFOS-1:0]  fifo_count
);
  import shfifo_pkg::*;

  addr_t  [`SHFIFO_NUM_FIFOS-1:0] head_q;
  addr_t  [`SHFIFO_NUM_FIFOS-1:0] tail_q;
  count_t [`SHFIFO_NUM_FIFOS-1:0] count_q;
  // Entry that follows each entry in its FIFO
  addr_t                          next_q [`SHFIFO_DEPTH];
  logic   [`SHFIFO_NUM_FIFOS-1:0] push_hit;
  logic   [`SHFIFO_NUM_FIFOS-1:0] adv_hit;

  assign head = head_q;
  assign fifo_count = count_q;

  always_comb begin
    for (int i = 0; i < `SHFIFO_NUM_FIFOS; i++) begin
      push_hit[i] = tail_upd_valid && (tail_upd.fifo_id == fifo_id_t'(i));
      adv_hit[i] = head_adv && (head_adv_id == fifo_id_t'(i));
    end
  end

  // Link the new entry behind the old tail, only when the FIFO holds something
  always_ff @(posedge clk) begin
    if (tail_upd_valid && (count_q[tail_upd.fifo_id] != '0)) begin
      next_q[tail_q[tail_upd.fifo_id]] <= tail_upd.addr;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      head_q <= '0;
      tail_q <= '0;
      count_q <= '0;
    end else begin
      for (int i = 0; i < `SHFIFO_NUM_FIFOS; i++) begin
        if (push_hit[i]) tail_q[i] <= tail_upd.addr;
        if (adv_hit[i]) begin
          // Last entry leaving while a new one arrives; the link is not
          // written yet, so take the new entry directly
          if (push_hit[i] && (count_q[i] == count_t'(1))) begin
            head_q[i] <= tail_upd.addr;
          end else begin
            head_q[i] <= next_q[head_q[i]];
          end
        end else if (push_hit[i] && (count_q[i] == '0)) begin
          head_q[i] <= tail_upd.addr;
        end
        count_q[i] <= count_q[i] + count_t'(push_hit[i]) - count_t'(adv_hit[i]);
      end
    end
  end

  // Pop controller only reads from FIFOs it saw as non-empty
  no_adv_on_empty_a: assert property (@(posedge clk) disable iff (rst)
    head_adv |-> (count_q[head_adv_id] != '0));

  for (genvar g = 0; g < `SHFIFO_NUM_FIFOS; g++) begin : gen_count_chk
    count_in_range_a: assert property (@(posedge clk) disable iff (rst)
      count_q[g] <= count_t'(`SHFIFO_DEPTH));
  end

endmodule

//--- verilog/shfifo_push_ctrl.sv
// Push controller
// Grants pushes against free entries and per-FIFO limits, writes the RAM
// and hands the new entry to the linked list as the FIFO tail

`timescale 1ns/1ps
`include "shfifo_config.svh"

module shfifo_push_ctrl (
  input  logic                                         push_valid,
  input  shfifo_pkg::push_req_t                        push_req,
  output logic                                         push_ready,
  input  logic                                         alloc_sendable,
  input  shfifo_pkg::addr_t                            alloc_entry,
  output logic                                         alloc_take,
  input  shfifo_pkg::count_t [`SHFIFO_NUM_FIFOS-1:0]   fifo_count,
  input  shfifo_pkg::count_t [`SHFIFO_NUM_FIFOS-1:0]   fifo_limit,
  output logic                                         ram_wr_valid,
  output shfifo_pkg::ram_wr_t                          ram_wr,
  output logic                                         tail_upd_valid,
  output shfifo_pkg::tail_upd_t                        tail_upd
);
  import shfifo_pkg::*;

  fifo_id_t id;
  logic     under_limit;
  logic     grant;

  assign id = push_req.fifo_id;
  // Limit is checked only for the FIFO being pushed
  assign under_limit = fifo_count[id] < fifo_limit[id];

  assign push_ready = alloc_sendable && under_limit;
  assign grant = push_valid && push_ready;
  assign alloc_take = grant;

  // RAM write and tail append are the same event
  assign ram_wr_valid = grant;
  assign ram_wr.addr = alloc_entry;
  assign ram_wr.data = push_req.data;

  assign tail_upd_valid = grant;
  assign tail_upd.fifo_id = id;
  assign tail_upd.addr = alloc_entry;

endmodule

//--- verilog/shfifo_freelist.sv
// Free-list tracker for the shared entries
// Offers the lowest free entry and recycles returned entries after a fixed delay

`timescale 1ns/1ps
`include "shfifo_config.svh"

module shfifo_freelist (
  input  logic                clk,
  input  logic                rst,
  output logic                alloc_sendable,
  output shfifo_pkg::addr_t   alloc_entry,
  input  logic                alloc_take,
  input  shfifo_pkg::dealloc_t dealloc,
  output logic                dealloc_count,
  output shfifo_pkg::count_t  free_count
);
  import shfifo_pkg::*;

  logic [`SHFIFO_DEPTH-1:0] free_q;
  logic [`SHFIFO_DEPTH-1:0] free_d;
  logic                     init_q;
  // Returned entries in flight; the last stage rejoins the bitmap
  dealloc_t                 pipe_q [0:`SHFIFO_DEALLOC_DELAY-2];
  dealloc_t                 ret;

  assign ret = pipe_q[`SHFIFO_DEALLOC_DELAY-2];

  // Nothing is offered until the cycle after reset release
  assign alloc_sendable = init_q && |free_q;
  assign free_count = count_t'($countones(free_q));

  // Priority pick, lowest index wins
  always_comb begin
    alloc_entry = '0;
    for (int i = `SHFIFO_DEPTH - 1; i >= 0; i--) begin
      if (free_q[i]) alloc_entry = addr_t'(i);
    end
  end

  always_comb begin
    free_d = free_q;
    if (alloc_take) free_d[alloc_entry] = 1'b0;
    if (ret.valid) free_d[ret.addr] = 1'b1;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      init_q <= 1'b0;
      free_q <= '1;
      dealloc_count <= 1'b0;
      for (int i = 0; i < `SHFIFO_DEALLOC_DELAY - 1; i++) pipe_q[i] <= '0;
    end else begin
      init_q <= 1'b1;
      free_q <= free_d;
      // Reported in the same cycle the entry shows as free
      dealloc_count <= ret.valid;
      pipe_q[0] <= dealloc;
      for (int i = 1; i < `SHFIFO_DEALLOC_DELAY - 1; i++) pipe_q[i] <= pipe_q[i-1];
    end
  end

  take_when_sendable_a: assert property (@(posedge clk) disable iff (rst)
    alloc_take |-> alloc_sendable);

  // Pop side may only return entries that the push side took
  no_double_free_a: assert property (@(posedge clk) disable iff (rst)
    dealloc.valid |-> !free_q[dealloc.addr]);

endmodule

//--- verilog/shfifo_pkg.sv
// Shared-storage multi-FIFO types
// Entry, FIFO and payload widths plus the bundles passed between blocks

`include "shfifo_config.svh"

package shfifo_pkg;

  typedef logic [$clog2(`SHFIFO_DEPTH)-1:0] addr_t;
  typedef logic [$clog2(`SHFIFO_NUM_FIFOS)-1:0] fifo_id_t;
  typedef logic [`SHFIFO_WIDTH-1:0] data_t;
  // Holds 0 through DEPTH inclusive
  typedef logic [$clog2(`SHFIFO_DEPTH + 1)-1:0] count_t;

  typedef struct packed {
    fifo_id_t fifo_id;
    data_t    data;
  } push_req_t;

  typedef struct packed {
    addr_t addr;
    data_t data;
  } ram_wr_t;

  typedef struct packed {
    fifo_id_t fifo_id;
    addr_t    addr;
  } tail_upd_t;

  typedef struct packed {
    logic  valid;
    addr_t addr;
  } dealloc_t;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  // Read sequencer; POP_READ means RAM data comes back this cycle
  typedef enum logic {
    POP_IDLE,
    POP_READ
  } pop_state_e;

endpackage

//--- include/shfifo_config.svh
// Shared-storage multi-FIFO configuration
// Fixed sizes for the entry RAM, the logical FIFOs and entry recycling

`ifndef SHFIFO_CONFIG_SVH
`define SHFIFO_CONFIG_SVH

// Shared entries in the data RAM
`define SHFIFO_DEPTH 8
// Logical FIFOs sharing the entries
`define SHFIFO_NUM_FIFOS 2
// Payload width
`define SHFIFO_WIDTH 16
// Cycles from a deallocation until the entry can be handed out again
`define SHFIFO_DEALLOC_DELAY 2

`endif
